/* common/cp0Pkg.sv */
// CP0 shared definitions: sizes, register addresses, exception types and codes,
// Status/Cause field positions, exception vectors and the move-to word union
package cp0Pkg;

    localparam int dataWidth    = 32;
    localparam int hardIntWidth = 6;

    // CP0 register numbers (select 0)
    localparam logic [4:0] regBadVAddr = 5'd8;
    localparam logic [4:0] regCount    = 5'd9;
    localparam logic [4:0] regCompare  = 5'd11;
    localparam logic [4:0] regStatus   = 5'd12;
    localparam logic [4:0] regCause    = 5'd13;
    localparam logic [4:0] regEpc      = 5'd14;
    localparam logic [4:0] regPrId     = 5'd15;

    localparam logic [dataWidth-1:0] prIdValue = 32'h0001_8000;

    // Exception kinds the arbiter can commit
    typedef enum logic [3:0] {
        excNone = 4'd0,
        excIntr,
        excAdEL,
        excCpU,
        excRI,
        excOv,
        excTrap,
        excSys,
        excBp,
        excAdES,
        excEret
    } excType_e;

    // Cause.ExcCode values
    localparam logic [4:0] codeIntr = 5'd0;
    localparam logic [4:0] codeAdEL = 5'd4;
    localparam logic [4:0] codeAdES = 5'd5;
    localparam logic [4:0] codeSys  = 5'd8;
    localparam logic [4:0] codeBp   = 5'd9;
    localparam logic [4:0] codeRI   = 5'd10;
    localparam logic [4:0] codeCpU  = 5'd11;
    localparam logic [4:0] codeOv   = 5'd12;
    localparam logic [4:0] codeTr   = 5'd13;

    // Status bit positions
    localparam int posCU0  = 28;
    localparam int posBEV  = 22;
    localparam int posIMHi = 15;
    localparam int posIMLo = 8;
    localparam int posUM   = 4;
    localparam int posERL  = 2;
    localparam int posEXL  = 1;
    localparam int posIE   = 0;

    // Software interrupt bits inside Cause.IP
    localparam int posIPSwHi = 9;
    localparam int posIPSwLo = 8;

    localparam logic [dataWidth-1:0] vecBoot   = 32'hBFC0_0380;
    localparam logic [dataWidth-1:0] vecNormal = 32'h8000_0180;

    typedef struct packed {
        logic [2:0] pad31;
        logic       cu0;       // 28
        logic [4:0] pad27;
        logic       bev;       // 22
        logic [5:0] pad21;
        logic [7:0] im;        // 15:8
        logic [2:0] pad7;
        logic       um;        // 4
        logic       pad3;
        logic       erl;       // 2
        logic       exl;       // 1
        logic       ie;        // 0
    } statusView_t;

    typedef struct packed {
        logic        bd;       // 31
        logic        pad30;
        logic [1:0]  ce;       // 29:28
        logic [11:0] pad27;
        logic [7:0]  ip;       // 15:8, only 9:8 writable
        logic        pad7;
        logic [4:0]  excCode;  // 6:2
        logic [1:0]  pad1;
    } causeView_t;

    // One move-to word, seen as Status or as Cause
    typedef union packed {
        statusView_t statusView;
        causeView_t  causeView;
    } cp0Word_u;

endpackage

/* cp0/cp0Regs.sv */
// CP0 register file: Status, Cause, EPC, BadVAddr, Count/Compare timer,
// interrupt line sampling and exception commit updates
`timescale 1ns/1ps

module cp0Regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cp0Pkg::hardIntWidth-1:0] intr,
    input  logic [4:0]                      addr,
    input  logic                            wen,
    input  logic [cp0Pkg::dataWidth-1:0]    wdata,
    output logic [cp0Pkg::dataWidth-1:0]    rdata,
    input  logic                            excFlag,
    input  cp0Pkg::excType_e                excType,
    input  logic [cp0Pkg::dataWidth-1:0]    pc,
    input  logic [cp0Pkg::dataWidth-1:0]    badAddr,
    input  logic [1:0]                      cpNum,
    input  logic                            inSlot,
    output logic [cp0Pkg::dataWidth-1:0]    status,
    output logic [cp0Pkg::dataWidth-1:0]    cause,
    output logic [cp0Pkg::dataWidth-1:0]    epc,
    output logic                            timerInt,
    output logic                            userMode
);
    import cp0Pkg::*;

    logic [dataWidth-1:0] badVAddrQ;
    logic [dataWidth-1:0] countQ;
    logic [dataWidth-1:0] compareQ;
    logic [dataWidth-1:0] epcQ;

    // Status fields
    logic       stCu0;
    logic       stBev;
    logic [7:0] stIm;
    logic       stUm;
    logic       stErl;
    logic       stExl;
    logic       stIe;

    // Cause fields
    logic       caBd;
    logic [1:0] caCe;
    logic [7:0] caIp;
    logic [4:0] caExcCode;

    cp0Word_u wView;
    cp0Word_u statusWord;
    cp0Word_u causeWord;

    logic [dataWidth-1:0] pcMinus4;
    logic                 timerHit;

    function automatic logic [4:0] excCodeOf(input excType_e kind);
        logic [4:0] code;
        case (kind)
            excAdEL: code = codeAdEL;
            excAdES: code = codeAdES;
            excCpU:  code = codeCpU;
            excRI:   code = codeRI;
            excOv:   code = codeOv;
            excTrap: code = codeTr;
            excSys:  code = codeSys;
            excBp:   code = codeBp;
            default: code = codeIntr;
        endcase
        return code;
    endfunction

    assign wView    = wdata;
    assign pcMinus4 = pc - 32'd4;
    assign timerHit = (compareQ != '0) && (countQ == compareQ); // Compare of zero never fires

    // Pack the fields back into architectural words
    always_comb begin
        statusWord                    = '0;
        statusWord.statusView.cu0     = stCu0;
        statusWord.statusView.bev     = stBev;
        statusWord.statusView.im      = stIm;
        statusWord.statusView.um      = stUm;
        statusWord.statusView.erl     = stErl;
        statusWord.statusView.exl     = stExl;
        statusWord.statusView.ie      = stIe;

        causeWord                     = '0;
        causeWord.causeView.bd        = caBd;
        causeWord.causeView.ce        = caCe;
        causeWord.causeView.ip        = caIp;
        causeWord.causeView.excCode   = caExcCode;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badVAddrQ <= '0;
            countQ    <= '0;
            compareQ  <= '0;
            epcQ      <= '0;
            timerInt  <= 1'b0;
            stCu0     <= 1'b0;
            stBev     <= 1'b1;      // Boot vectors until software clears it
            stIm      <= '0;
            stUm      <= 1'b0;
            stErl     <= 1'b1;
            stExl     <= 1'b0;
            stIe      <= 1'b0;
            caBd      <= 1'b0;
            caCe      <= '0;
            caIp      <= '0;
            caExcCode <= '0;
        end else begin
            countQ <= countQ + 32'd1;
            if (timerHit) begin
                timerInt <= 1'b1;
            end

            // Hardware IP lines, timer shares line 5
            caIp[7:2] <= {intr[5] | timerInt, intr[4:0]};

            if (excFlag) begin
                if (excType == excEret) begin
                    stExl <= 1'b0;
                end else begin
                    // Nested exception keeps the original return point
                    if (!stExl) begin
                        epcQ <= inSlot ? pcMinus4 : pc;
                        caBd <= inSlot;
                    end
                    stExl     <= 1'b1;
                    caExcCode <= excCodeOf(excType);
                    if (excType == excAdEL || excType == excAdES) begin
                        badVAddrQ <= badAddr;
                    end
                    if (excType == excCpU) begin
                        caCe <= cpNum;
                    end
                end
            end else if (wen) begin
                case (addr)
                    regBadVAddr: badVAddrQ <= wdata;
                    regCount:    countQ    <= wdata;   // Overrides the increment
                    regCompare: begin
                        compareQ <= wdata;
                        timerInt <= 1'b0;             // Acknowledge the timer
                    end
                    regStatus: begin
                        stCu0 <= wView.statusView.cu0;
                        stBev <= wView.statusView.bev;
                        stIm  <= wView.statusView.im;
                        stUm  <= wView.statusView.um;
                        stErl <= wView.statusView.erl;
                        stExl <= wView.statusView.exl;
                        stIe  <= wView.statusView.ie;
                    end
                    regCause:    caIp[1:0] <= wView.causeView.ip[1:0]; // Software IP only
                    regEpc:      epcQ      <= wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr)
            regBadVAddr: rdata = badVAddrQ;
            regCount:    rdata = countQ;
            regCompare:  rdata = compareQ;
            regStatus:   rdata = statusWord;
            regCause:    rdata = causeWord;
            regEpc:      rdata = epcQ;
            regPrId:     rdata = prIdValue;
            default:     rdata = '0;
        endcase
    end

    assign status   = statusWord;
    assign cause    = causeWord;
    assign epc      = epcQ;
    assign userMode = status[posUM] & ~(status[posEXL] | status[posERL]);

endmodule

/* cp0/cp0ExcArbiter.sv */
// Exception arbiter: pending interrupt detection, MIPS priority selection
// and the fetch redirect vector
`timescale 1ns/1ps

module cp0ExcArbiter (
    input  logic [cp0Pkg::dataWidth-1:0] status,
    input  logic [cp0Pkg::dataWidth-1:0] cause,
    input  logic [cp0Pkg::dataWidth-1:0] epc,
    input  logic                         reqAdEL,
    input  logic                         reqCpU,
    input  logic                         reqRI,
    input  logic                         reqOv,
    input  logic                         reqTrap,
    input  logic                         reqSys,
    input  logic                         reqBp,
    input  logic                         reqAdES,
    input  logic                         reqEret,
    output logic                         excFlag,
    output cp0Pkg::excType_e             excType,
    output logic [cp0Pkg::dataWidth-1:0] excVector
);
    import cp0Pkg::*;

    logic [7:0] ipMasked;
    logic       intEnabled;
    logic       intrPending;

    // IP and IM share bit positions 15:8
    assign ipMasked    = cause[posIMHi:posIMLo] & status[posIMHi:posIMLo];
    assign intEnabled  = status[posIE] & ~status[posEXL] & ~status[posERL];
    assign intrPending = (|ipMasked) & intEnabled;

    // Highest priority first
    always_comb begin
        if (intrPending) begin
            excType = excIntr;
        end else if (reqAdEL) begin
            excType = excAdEL;      // Fetch address error
        end else if (reqCpU) begin
            excType = excCpU;
        end else if (reqRI) begin
            excType = excRI;
        end else if (reqOv) begin
            excType = excOv;
        end else if (reqTrap) begin
            excType = excTrap;
        end else if (reqSys) begin
            excType = excSys;
        end else if (reqBp) begin
            excType = excBp;
        end else if (reqAdES) begin
            excType = excAdES;      // Data store address error
        end else if (reqEret) begin
            excType = excEret;
        end else begin
            excType = excNone;
        end
    end

    assign excFlag = (excType != excNone);

    always_comb begin
        if (excType == excEret) begin
            excVector = epc;
        end else if (status[posBEV]) begin
            excVector = vecBoot;
        end else begin
            excVector = vecNormal;
        end
    end

endmodule

/* source/cp0Unit.sv */
// CP0 top level: exception arbiter beside the register file
`timescale 1ns/1ps

module cp0Unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cp0Pkg::hardIntWidth-1:0] intr,
    input  logic [4:0]                      addr,
    input  logic                            wen,
    input  logic [cp0Pkg::dataWidth-1:0]    wdata,
    output logic [cp0Pkg::dataWidth-1:0]    rdata,
    input  logic                            reqAdEL,
    input  logic                            reqCpU,
    input  logic                            reqRI,
    input  logic                            reqOv,
    input  logic                            reqTrap,
    input  logic                            reqSys,
    input  logic                            reqBp,
    input  logic                            reqAdES,
    input  logic                            reqEret,
    input  logic [cp0Pkg::dataWidth-1:0]    pc,
    input  logic [cp0Pkg::dataWidth-1:0]    badAddr,
    input  logic [1:0]                      cpNum,
    input  logic                            inSlot,
    output logic                            excFlag,
    output logic [cp0Pkg::dataWidth-1:0]    excVector,
    output logic                            timerInt,
    output logic                            userMode,
    output logic [cp0Pkg::dataWidth-1:0]    statusOut,
    output logic [cp0Pkg::dataWidth-1:0]    causeOut,
    output logic [cp0Pkg::dataWidth-1:0]    epcOut
);
    import cp0Pkg::*;

    excType_e excType;

    cp0ExcArbiter uArbiter (
        .status   (statusOut),
        .cause    (causeOut),
        .epc      (epcOut),
        .reqAdEL  (reqAdEL),
        .reqCpU   (reqCpU),
        .reqRI    (reqRI),
        .reqOv    (reqOv),
        .reqTrap  (reqTrap),
        .reqSys   (reqSys),
        .reqBp    (reqBp),
        .reqAdES  (reqAdES),
        .reqEret  (reqEret),
        .excFlag  (excFlag),
        .excType  (excType),
        .excVector(excVector)
    );

    cp0Regs uRegs (
        .clk     (clk),
        .rst     (rst),
        .intr    (intr),
        .addr    (addr),
        .wen     (wen),
        .wdata   (wdata),
        .rdata   (rdata),
        .excFlag (excFlag),
        .excType (excType),
        .pc      (pc),
        .badAddr (badAddr),
        .cpNum   (cpNum),
        .inSlot  (inSlot),
        .status  (statusOut),
        .cause   (causeOut),
        .epc     (epcOut),
        .timerInt(timerInt),
        .userMode(userMode)
    );

endmodule

/* tb/cp0Model.svh */
// Shadow CP0 registers and reference functions for reads, priority choice,
// redirect vector and the commit and write updates
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

// Writable Status bits only
localparam logic [31:0] statusMask = (32'd1 << posCU0) | (32'd1 << posBEV) |
    (32'hFF << posIMLo) | (32'd1 << posUM) | (32'd1 << posERL) |
    (32'd1 << posEXL) | (32'd1 << posIE);

cp0Word_u    shStatus;
cp0Word_u    shCause;
logic [31:0] shEpc;
logic [31:0] shBadVAddr;
logic [31:0] shCount;
logic [31:0] shCompare;
logic        shTimer;

function automatic void resetShadow();
    shStatus                = '0;
    shStatus.statusView.bev = 1'b1;
    shStatus.statusView.erl = 1'b1;
    shCause                 = '0;
    shEpc                   = '0;
    shBadVAddr              = '0;
    shCount                 = '0;
    shCompare               = '0;
    shTimer                 = 1'b0;
endfunction

function automatic logic [31:0] readShadow(input logic [4:0] a);
    case (a)
        regBadVAddr: return shBadVAddr;
        regCount:    return shCount;
        regCompare:  return shCompare;
        regStatus:   return shStatus & statusMask;
        regCause:    return shCause;
        regEpc:      return shEpc;
        regPrId:     return prIdValue;
        default:     return 32'd0;
    endcase
endfunction

function automatic logic expectedUserMode();
    return shStatus.statusView.um && !shStatus.statusView.exl && !shStatus.statusView.erl;
endfunction

// Maps a request bit to its exception kind
function automatic excType_e kindOfBit(input int i);
    case (i)
        0:       return excAdEL;
        1:       return excCpU;
        2:       return excRI;
        3:       return excOv;
        4:       return excTrap;
        5:       return excSys;
        6:       return excBp;
        7:       return excAdES;
        default: return excEret;
    endcase
endfunction

function automatic excType_e pickException(input logic [8:0] req);
    excType_e kind;
    kind = excNone;
    for (int i = 8; i >= 0; i--) begin
        if (req[i]) kind = kindOfBit(i);   // Last hit is the highest priority
    end
    if ((|(shCause.causeView.ip & shStatus.statusView.im)) && shStatus.statusView.ie &&
        !shStatus.statusView.exl && !shStatus.statusView.erl) kind = excIntr;
    return kind;
endfunction

function automatic logic [31:0] redirectVector(input excType_e kind);
    if (kind == excEret) return shEpc;
    return shStatus.statusView.bev ? vecBoot : vecNormal;
endfunction

function automatic logic [4:0] codeForKind(input excType_e kind);
    case (kind)
        excAdEL: return codeAdEL;
        excAdES: return codeAdES;
        excCpU:  return codeCpU;
        excRI:   return codeRI;
        excOv:   return codeOv;
        excTrap: return codeTr;
        excSys:  return codeSys;
        excBp:   return codeBp;
        default: return codeIntr;
    endcase
endfunction

// State after the coming clock edge
function automatic void advanceShadow(input logic [4:0] a, input logic we,
    input logic [31:0] wd, input excType_e kind, input logic [31:0] pcV,
    input logic [31:0] bad, input logic [1:0] cpn, input logic slot, input logic [5:0] irq);
    cp0Word_u wv;
    logic     hit;
    wv  = wd;
    hit = (shCompare != 0) && (shCount == shCompare);
    shCause.causeView.ip[7:2] = {irq[5] | shTimer, irq[4:0]};
    if (hit) shTimer = 1'b1;
    shCount = shCount + 32'd1;
    if (kind == excEret) begin
        shStatus.statusView.exl = 1'b0;
    end else if (kind != excNone) begin
        if (!shStatus.statusView.exl) begin
            shEpc                = slot ? pcV - 32'd4 : pcV;
            shCause.causeView.bd = slot;
        end
        shStatus.statusView.exl   = 1'b1;
        shCause.causeView.excCode = codeForKind(kind);
        if (kind == excAdEL || kind == excAdES) shBadVAddr = bad;
        if (kind == excCpU) shCause.causeView.ce = cpn;
    end else if (we) begin
        case (a)
            regBadVAddr: shBadVAddr = wd;
            regCount:    shCount = wd;
            regCompare: begin
                shCompare = wd;
                shTimer   = 1'b0;
            end
            regStatus:   shStatus = wd & statusMask;
            regCause:    shCause.causeView.ip[1:0] = wv.causeView.ip[1:0];
            regEpc:      shEpc = wd;
            default: ;
        endcase
    end
endfunction

`endif

/* tb/cp0Tb.sv */
// CP0 testbench with clock, reset, stimulus sequences, per-cycle compare
// against the shadow model and a watchdog
`timescale 1ns/1ps

module cp0Tb;
    import cp0Pkg::*;

    localparam int clkPeriod  = 20;
    localparam int regRounds  = 36;
    localparam int timerWait  = 40;
    localparam int excRounds  = 12;
    localparam int prioRounds = 30;
    localparam int eretRounds = 4;
    // Cycles of every sequence in order
    localparam int runCycles = 3 + regRounds * 2 + 35 + timerWait + 12 + excRounds * 7 +
        prioRounds * 3 + eretRounds * 4 + 2 + 1 + hardIntWidth * 7 + 5 + 3;
    localparam int watchdogCycles = runCycles + 100;
    localparam logic [8:0]  bitSys  = 9'h020;
    localparam logic [8:0]  bitEret = 9'h100;
    localparam logic [31:0] seed    = 32'h329404df;

    logic        clk;
    logic        rst;
    logic [5:0]  intr;
    logic [4:0]  addr;
    logic        wen;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [8:0]  reqBits;   // AdEL in bit 0 up to Eret in bit 8
    logic [31:0] pc;
    logic [31:0] badAddr;
    logic [1:0]  cpNum;
    logic        inSlot;
    logic        excFlag;
    logic [31:0] excVector;
    logic        timerInt;
    logic        userMode;
    logic [31:0] statusOut;
    logic [31:0] causeOut;
    logic [31:0] epcOut;
    int unsigned seedVal;
    logic        modelOn;

    `include "cp0Model.svh"

    cp0Unit i_cp0Unit (
        .clk(clk), .rst(rst), .intr(intr), .addr(addr), .wen(wen), .wdata(wdata),
        .rdata(rdata), .reqAdEL(reqBits[0]), .reqCpU(reqBits[1]), .reqRI(reqBits[2]),
        .reqOv(reqBits[3]), .reqTrap(reqBits[4]), .reqSys(reqBits[5]), .reqBp(reqBits[6]),
        .reqAdES(reqBits[7]), .reqEret(reqBits[8]), .pc(pc), .badAddr(badAddr),
        .cpNum(cpNum), .inSlot(inSlot), .excFlag(excFlag), .excVector(excVector),
        .timerInt(timerInt), .userMode(userMode), .statusOut(statusOut),
        .causeOut(causeOut), .epcOut(epcOut)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s is %h, expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string why);
        $display("ERROR @%0t: %s", $time, why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #2;
        wen     = 1'b0;
        reqBits = '0;
    endtask

    task automatic writeReg(input logic [4:0] a, input logic [31:0] d);
        stepCycle();
        addr  = a;
        wen   = 1'b1;
        wdata = d;
    endtask

    task automatic readReg(input logic [4:0] a);
        stepCycle();
        addr = a;
    endtask

    task automatic raiseExc(input logic [8:0] bits);
        stepCycle();
        reqBits = bits;
        pc      = $urandom & 32'hFFFF_FFFC;
        badAddr = $urandom;
        cpNum   = $urandom % 4;
        inSlot  = $urandom % 2;
    endtask

    function automatic logic [4:0] regAt(input int i);
        case (i % 6)
            0:       return regBadVAddr;
            1:       return regCount;
            2:       return regCompare;
            3:       return regStatus;
            4:       return regCause;
            default: return regEpc;
        endcase
    endfunction

    // Compare just before each edge and advance the model past it
    initial begin
        excType_e kind;
        forever begin
            @(posedge clk);
            #(clkPeriod - 3);
            if (modelOn) begin
                kind = pickException(reqBits);
                checkEq(rdata, readShadow(addr), "rdata");
                checkEq(excFlag, kind != excNone, "excFlag");
                if (kind != excNone) checkEq(excVector, redirectVector(kind), "excVector");
                checkEq(timerInt, shTimer, "timerInt");
                checkEq(userMode, expectedUserMode(), "userMode");
                checkEq(statusOut, shStatus & statusMask, "Status");
                checkEq(causeOut, shCause, "Cause");
                checkEq(epcOut, shEpc, "EPC");
                advanceShadow(addr, wen, wdata, kind, pc, badAddr, cpNum, inSlot, intr);
            end
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        abortRun($sformatf("timeout, run did not finish within %0d cycles", watchdogCycles));
    end

    initial begin
        logic [31:0] d;
        logic [31:0] base;
        logic [4:0]  a;
        logic [5:0]  r;
        int          n;
        seedVal  = seed;
        seedVal  = $urandom(seedVal);
        clk      = 1'b0;
        rst      = 1'b1;
        intr     = '0;
        addr     = '0;
        wen      = 1'b0;
        wdata    = '0;
        reqBits  = '0;
        pc       = '0;
        badAddr  = '0;
        cpNum    = '0;
        inSlot   = 1'b0;
        modelOn  = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        resetShadow();
        modelOn = 1'b1;

        // Random writes with one readback each
        for (int i = 0; i < regRounds; i++) begin
            a = regAt(i);
            d = $urandom;
            if (a == regStatus) d[posERL] = 1'b1;   // Keep interrupts blocked
            writeReg(a, d);
            readReg(a);
        end
        for (r = 0; r < 32; r++) readReg(r[4:0]);
        writeReg(regCause, '0);
        writeReg(regCompare, '0);
        writeReg(regStatus, 32'd1 << posBEV);

        // Timer
        base = $urandom & 32'h0FFF_FFFF;
        writeReg(regCount, base);
        repeat (5) readReg(regCount);
        writeReg(regCompare, base + 32'd20);
        n = 0;
        while (!timerInt && n < timerWait) begin
            readReg(regCount);
            n++;
        end
        if (!timerInt) abortRun("timer interrupt never rose after the Count/Compare match");
        readReg(regCause);
        writeReg(regCompare, '0);
        repeat (2) readReg(regCause);

        // Single commits and a nested one under EXL
        for (int i = 0; i < excRounds; i++) begin
            raiseExc(9'd1 << ($urandom % 8));
            readReg(regCause);
            readReg(regEpc);
            raiseExc(9'd1 << ($urandom % 8));
            readReg(regEpc);
            readReg(regBadVAddr);
            writeReg(regStatus, ($urandom % 2) << posBEV);
        end

        // Random request sets with a write that the commit drops
        for (int i = 0; i < prioRounds; i++) begin
            raiseExc($urandom % 512);
            addr  = regEpc;
            wen   = 1'b1;
            wdata = $urandom;
            readReg(regEpc);
            writeReg(regStatus, '0);
        end

        for (int i = 0; i < eretRounds; i++) begin
            writeReg(regStatus, 32'd1 << posUM);
            raiseExc(bitSys);
            readReg(regEpc);
            raiseExc(bitEret);
        end
        writeReg(regStatus, (32'd1 << posUM) | (32'd1 << posERL));
        readReg(regStatus);

        // Hardware lines with IE clear, IM masked and finally enabled
        writeReg(regStatus, '0);
        for (int j = 0; j < hardIntWidth; j++) begin
            stepCycle();
            intr = 6'd1 << j;
            readReg(regCause);
            writeReg(regStatus, 32'd1 << (posIMLo + 2 + j));
            writeReg(regStatus, (32'hFC00 & ~(32'd1 << (posIMLo + 2 + j))) | 32'd1);
            writeReg(regStatus, (32'd1 << (posIMLo + 2 + j)) | 32'd1);
            readReg(regCause);
            stepCycle();
            intr = '0;
        end
        writeReg(regStatus, '0);
        writeReg(regCause, 32'd1 << posIPSwLo);   // Software line 0
        writeReg(regStatus, (32'd1 << posIMLo) | 32'd1);
        readReg(regCause);
        writeReg(regCause, '0);

        repeat (3) stepCycle();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* sim.f */
+incdir+tb
common/cp0Pkg.sv
cp0/cp0Regs.sv
cp0/cp0ExcArbiter.sv
source/cp0Unit.sv
tb/cp0Tb.sv

/* Bender.yml */
package:
  name: cp0

sources:
  - common/cp0Pkg.sv
  - cp0/cp0Regs.sv
  - cp0/cp0ExcArbiter.sv
  - source/cp0Unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cp0Tb.sv
